/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log && rm -rf obj_dir &&
verilator --binary --assert -j 0 --top-module tb_wordcopy -Mdir obj_dir -f sources.f &&
./obj_dir/Vtb_wordcopy > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

/* sources.f */
src/wordcopy_pkg.sv
src/wordcopy_regs.sv
src/wordcopy_engine.sv
src/wordcopy_top.sv
test/tb_clock.sv
test/tb_sdram.sv
test/tb_wordcopy.sv

/* src/wordcopy_engine.sv */
`timescale 1ns/1ps

module wordcopy_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    // job settings from the register block
    input  logic                  start,
    input  wordcopy_pkg::wc_word_t src_addr,
    input  wordcopy_pkg::wc_word_t dest_addr,
    input  wordcopy_pkg::wc_word_t word_count,
    output logic                  busy,
    output wordcopy_pkg::wc_word_t copied_count,
    // memory master port
    input  logic                  master_waitrequest,
    output wordcopy_pkg::wc_word_t master_address,
    output logic                  master_read,
    input  wordcopy_pkg::wc_word_t master_readdata,
    input  logic                  master_readdatavalid,
    output logic                  master_write,
    output wordcopy_pkg::wc_word_t master_writedata
);

    wordcopy_pkg::wc_state_e state;

    wordcopy_pkg::wc_word_t src_q;        // working source address
    wordcopy_pkg::wc_word_t dst_q;        // working destination address
    wordcopy_pkg::wc_word_t remaining_q;  // words still to move in this job
    wordcopy_pkg::wc_word_t copied_q;     // words finished so far
    wordcopy_pkg::wc_word_t data_q;       // word in flight between read and write

    // every master output is a plain decode of state and registers, so
    // back-pressure just parks the FSM and the bus stays frozen with it
    assign master_read      = (state == wordcopy_pkg::ENG_READ_REQ);
    assign master_write     = (state == wordcopy_pkg::ENG_WRITE_REQ);
    assign master_address   = master_read ? src_q : dst_q;
    assign master_writedata = data_q;

    assign busy         = (state != wordcopy_pkg::ENG_IDLE);
    assign copied_count = copied_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= wordcopy_pkg::ENG_IDLE;
            src_q       <= '0;
            dst_q       <= '0;
            remaining_q <= '0;
            copied_q    <= '0;
        end else begin
            case (state)
                wordcopy_pkg::ENG_IDLE: begin
                    if (start) begin
                        // take a private copy so the settings are free again
                        src_q       <= src_addr;
                        dst_q       <= dest_addr;
                        remaining_q <= word_count;
                        copied_q    <= '0;
                        // an empty job goes straight to the count check in NEXT
                        if (word_count == '0) begin
                            state <= wordcopy_pkg::ENG_NEXT;
                        end else begin
                            state <= wordcopy_pkg::ENG_READ_REQ;
                        end
                    end
                end

                wordcopy_pkg::ENG_READ_REQ: begin
                    if (!master_waitrequest) begin
                        state <= wordcopy_pkg::ENG_READ_WAIT;  // read taken by the memory
                    end
                end

                wordcopy_pkg::ENG_READ_WAIT: begin
                    // only one read is ever out, so the first valid is ours
                    if (master_readdatavalid) begin
                        state <= wordcopy_pkg::ENG_WRITE_REQ;
                    end
                end

                wordcopy_pkg::ENG_WRITE_REQ: begin
                    if (!master_waitrequest) begin
                        // accepted write closes the word
                        remaining_q <= remaining_q - 32'd1;
                        copied_q    <= copied_q + 32'd1;
                        state       <= wordcopy_pkg::ENG_NEXT;
                    end
                end

                wordcopy_pkg::ENG_NEXT: begin
                    src_q <= src_q + wordcopy_pkg::WC_WORD_BYTES;
                    dst_q <= dst_q + wordcopy_pkg::WC_WORD_BYTES;
                    // the count is checked here before each further word
                    if (remaining_q == '0) begin
                        state <= wordcopy_pkg::ENG_IDLE;
                    end else begin
                        state <= wordcopy_pkg::ENG_READ_REQ;
                    end
                end

                default: state <= wordcopy_pkg::ENG_IDLE;  // unused encodings recover
            endcase
        end
    end

    // the returned word is taken in the one cycle the memory marks it valid
    always_ff @(posedge clk) begin
        if ((state == wordcopy_pkg::ENG_READ_WAIT) && master_readdatavalid) begin
            data_q <= master_readdata;
        end
    end

    // the master port carries one transfer at a time
    a_read_write_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(master_read && master_write)
    ) else $error("master read and write raised together");

    // addresses come from the CPU settings and are stepped by whole words,
    // so a misaligned request means bad settings or a broken step
    a_word_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        (master_read || master_write) |-> (master_address[1:0] == 2'b00)
    ) else $error("master address 0x%08h not word aligned", master_address);

endmodule

/* src/wordcopy_pkg.sv */
package wordcopy_pkg;

    // one bus word, used for data and for byte addresses alike
    typedef logic [31:0] wc_word_t;

    // byte step between consecutive words on the memory bus
    localparam wc_word_t WC_WORD_BYTES = 32'd4;

    // register offsets seen on the CPU port
    typedef enum logic [3:0] {
        REG_START_STATUS = 4'd0,  // write starts a job, read gives the last copied count
        REG_DEST         = 4'd1,  // destination byte address
        REG_SRC          = 4'd2,  // source byte address
        REG_COUNT        = 4'd3   // number of words to move
    } wc_reg_e;

    // copy engine states
    // one word walks READ_REQ, READ_WAIT, WRITE_REQ and then NEXT, where the
    // remaining count decides between another word and going idle
    typedef enum logic [2:0] {
        ENG_IDLE      = 3'd0,  // waiting for a start pulse
        ENG_READ_REQ  = 3'd1,  // read held on the bus until accepted
        ENG_READ_WAIT = 3'd2,  // read accepted, waiting for the data to come back
        ENG_WRITE_REQ = 3'd3,  // write held on the bus until accepted
        ENG_NEXT      = 3'd4   // step addresses and check what is left
    } wc_state_e;

endpackage

/* src/wordcopy_regs.sv */
`timescale 1ns/1ps

module wordcopy_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    // CPU side
    input  wordcopy_pkg::wc_reg_e  slave_address,
    input  logic                  slave_read,
    input  logic                  slave_write,
    input  wordcopy_pkg::wc_word_t slave_writedata,
    output wordcopy_pkg::wc_word_t slave_readdata,
    output logic                  slave_waitrequest,
    // engine side
    input  logic                  busy,
    input  wordcopy_pkg::wc_word_t copied_count,
    output logic                  start,
    output wordcopy_pkg::wc_word_t src_addr,
    output wordcopy_pkg::wc_word_t dest_addr,
    output wordcopy_pkg::wc_word_t word_count
);

    logic boot_q;      // high through reset so the CPU cannot get in early
    logic wr_accept;   // a write completes at this edge
    logic rd_accept;   // a read completes at this edge
    logic go_write;    // the accepted write targets the start offset

    // an access only completes in a cycle with the wait request low
    assign wr_accept = slave_write && !slave_waitrequest;
    assign rd_accept = slave_read && !slave_waitrequest;
    assign go_write  = wr_accept && (slave_address == wordcopy_pkg::REG_START_STATUS);

    // start covers the gap before busy comes up, busy covers the job itself,
    // so the two together hold the CPU off without a hole between them
    assign slave_waitrequest = boot_q || start || busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            boot_q <= 1'b1;
        end else begin
            boot_q <= 1'b0;  // drops at the first edge out of reset
        end
    end

    // start is a single-cycle pulse following the accepted write to offset 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= go_write;
        end
    end

    // job settings, written only while the engine is idle since the wait
    // request blocks every write during a job
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_addr  <= '0;
            src_addr   <= '0;
            word_count <= '0;
        end else if (wr_accept) begin
            case (slave_address)
                wordcopy_pkg::REG_DEST:  dest_addr  <= slave_writedata;
                wordcopy_pkg::REG_SRC:   src_addr   <= slave_writedata;
                wordcopy_pkg::REG_COUNT: word_count <= slave_writedata;
                default: ;  // offset 0 only fires start, others are ignored
            endcase
        end
    end

    // read data lands one cycle after the access completes
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            case (slave_address)
                wordcopy_pkg::REG_START_STATUS: slave_readdata <= copied_count;
                wordcopy_pkg::REG_DEST:         slave_readdata <= dest_addr;
                wordcopy_pkg::REG_SRC:          slave_readdata <= src_addr;
                wordcopy_pkg::REG_COUNT:        slave_readdata <= word_count;
                default:                        slave_readdata <= '0;  // unmapped offsets
            endcase
        end
    end

    // a second start during a job would mean the wait request failed to
    // hold the CPU back while the engine was working
    a_no_start_when_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(start) |-> !busy
    ) else $error("start pulse raised while the engine is busy");

endmodule

/* src/wordcopy_top.sv */
`timescale 1ns/1ps

module wordcopy_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // CPU slave port
    input  wordcopy_pkg::wc_reg_e  slave_address,
    input  logic                  slave_read,
    input  logic                  slave_write,
    input  wordcopy_pkg::wc_word_t slave_writedata,
    output wordcopy_pkg::wc_word_t slave_readdata,
    output logic                  slave_waitrequest,
    // memory master port
    input  logic                  master_waitrequest,
    output wordcopy_pkg::wc_word_t master_address,
    output logic                  master_read,
    input  wordcopy_pkg::wc_word_t master_readdata,
    input  logic                  master_readdatavalid,
    output logic                  master_write,
    output wordcopy_pkg::wc_word_t master_writedata
);

    logic                   start;         // one-cycle job kick
    logic                   busy;          // engine is working a job
    wordcopy_pkg::wc_word_t copied_count;  // progress back to the CPU
    wordcopy_pkg::wc_word_t src_addr;
    wordcopy_pkg::wc_word_t dest_addr;
    wordcopy_pkg::wc_word_t word_count;

    // CPU registers and the wait request that stalls the CPU during a job
    wordcopy_regs u_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .slave_address     (slave_address),
        .slave_read        (slave_read),
        .slave_write       (slave_write),
        .slave_writedata   (slave_writedata),
        .slave_readdata    (slave_readdata),
        .slave_waitrequest (slave_waitrequest),
        .busy              (busy),
        .copied_count      (copied_count),
        .start             (start),
        .src_addr          (src_addr),
        .dest_addr         (dest_addr),
        .word_count        (word_count)
    );

    // word mover on the memory side
    wordcopy_engine u_engine (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start                (start),
        .src_addr             (src_addr),
        .dest_addr            (dest_addr),
        .word_count           (word_count),
        .busy                 (busy),
        .copied_count         (copied_count),
        .master_waitrequest   (master_waitrequest),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .master_write         (master_write),
        .master_writedata     (master_writedata)
    );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 10 ns period, first rising edge at 5 ns
    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);  // reset is seen at two rising edges
        @(negedge clk);
        rst_n = 1'b1;               // released on a falling edge like every other input
    end

endmodule

/* test/tb_sdram.sv */
`timescale 1ns/1ps

module tb_sdram #(
    parameter int unsigned SEED = 32'h13c9
) (
    input  logic                   clk,
    input  wordcopy_pkg::wc_word_t address,
    input  logic                   read,
    input  logic                   write,
    input  wordcopy_pkg::wc_word_t writedata,
    output logic                   waitrequest,
    output wordcopy_pkg::wc_word_t readdata,
    output logic                   readdatavalid
);

    localparam int DEPTH = 1024;

    wordcopy_pkg::wc_word_t mem [DEPTH];  // 4 KiB of byte address space
    logic [9:0]  rd_idx;                  // word index of the read in flight
    logic [2:0]  delay;                   // cycles left before that read returns

    // every word starts as its own byte address mixed with a fixed tag
    task automatic preload();
        for (int i = 0; i < DEPTH; i++) begin
            mem[10'(i)] = wordcopy_pkg::wc_word_t'(i * 4) ^ 32'hA5A5_0000;
        end
    endtask

    // the model runs on the falling edge, so the DUT sees settled values at
    // the rising edge and the requests sampled here are already stable
    initial begin
        void'($urandom(SEED));  // the only seed of the run
        waitrequest   = 1'b1;
        readdata      = '0;
        readdatavalid = 1'b0;
        delay         = 3'd0;
        rd_idx        = 10'd0;
        forever begin
            @(negedge clk);
            readdatavalid = 1'b0;  // returned data is shown for exactly one cycle
            if (delay != 3'd0) begin
                delay = delay - 3'd1;
                if (delay == 3'd0) begin
                    readdatavalid = 1'b1;
                    readdata      = mem[rd_idx];
                end
            end
            // stall roughly one cycle in four, whether or not a request is up
            waitrequest = ($urandom % 4) == 0;
            if (read && !waitrequest) begin
                rd_idx = address[11:2];
                delay  = 3'(1 + $urandom % 4);  // latency of 1 to 4 cycles
            end
            if (write && !waitrequest) begin
                mem[address[11:2]] = writedata;  // taken at the coming rising edge
            end
        end
    end

endmodule

/* test/tb_wordcopy.sv */
`timescale 1ns/1ps

module tb_wordcopy;

    logic                   clk;
    logic                   rst_n;
    wordcopy_pkg::wc_reg_e  slave_address;
    logic                   slave_read;
    logic                   slave_write;
    wordcopy_pkg::wc_word_t slave_writedata;
    wordcopy_pkg::wc_word_t slave_readdata;
    logic                   slave_waitrequest;
    logic                   master_waitrequest;
    wordcopy_pkg::wc_word_t master_address;
    logic                   master_read;
    wordcopy_pkg::wc_word_t master_readdata;
    logic                   master_readdatavalid;
    logic                   master_write;
    wordcopy_pkg::wc_word_t master_writedata;

    // jobs as read from the data file
    string                  test_name [$];
    wordcopy_pkg::wc_word_t test_src [$];
    wordcopy_pkg::wc_word_t test_dst [$];
    wordcopy_pkg::wc_word_t test_cnt [$];

    wordcopy_pkg::wc_word_t shadow [1024];  // predicted memory contents
    int mismatches = 0;
    int other_errors = 0;
    int total_words = 0;
    int cycle_limit = 0;   // zero until the tests are known
    int cycle_count = 0;

    tb_clock clk0 (.clk(clk), .rst_n(rst_n));

    tb_sdram #(.SEED(32'h13c9)) mem0 (
        .clk(clk), .address(master_address), .read(master_read), .write(master_write),
        .writedata(master_writedata), .waitrequest(master_waitrequest),
        .readdata(master_readdata), .readdatavalid(master_readdatavalid)
    );

    wordcopy_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .slave_address(slave_address), .slave_read(slave_read),
        .slave_write(slave_write), .slave_writedata(slave_writedata),
        .slave_readdata(slave_readdata), .slave_waitrequest(slave_waitrequest),
        .master_waitrequest(master_waitrequest), .master_address(master_address),
        .master_read(master_read), .master_readdata(master_readdata),
        .master_readdatavalid(master_readdatavalid), .master_write(master_write),
        .master_writedata(master_writedata)
    );

    task automatic check_word(input string name, input wordcopy_pkg::wc_word_t expected,
                              input wordcopy_pkg::wc_word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_count(input string name, input wordcopy_pkg::wc_word_t expected,
                               input wordcopy_pkg::wc_word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s copied count: expected %0d, actual %0d",
                     name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic load_tests();
        int fd;
        int got;
        string line;
        string name;
        wordcopy_pkg::wc_word_t src;
        wordcopy_pkg::wc_word_t dst;
        wordcopy_pkg::wc_word_t cnt;
        fd = $fopen("test/wordcopy_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/wordcopy_tests.txt for reading");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 1 && line.getc(0) != "#") begin  // skip blank and comment lines
                got = $sscanf(line, "%s %h %h %h", name, src, dst, cnt);
                if (got == 4) begin
                    test_name.push_back(name);
                    test_src.push_back(src);
                    test_dst.push_back(dst);
                    test_cnt.push_back(cnt);
                end else begin
                    $display("test line could not be read: %s", line);
                    other_errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on the falling edge after the write is taken
    task automatic bus_write(input wordcopy_pkg::wc_reg_e offset,
                             input wordcopy_pkg::wc_word_t data);
        slave_address   = offset;
        slave_writedata = data;
        slave_write     = 1'b1;
        while (slave_waitrequest) @(negedge clk);
        @(negedge clk);  // accepted at the rising edge just passed
        slave_write = 1'b0;
    endtask

    task automatic bus_read(input wordcopy_pkg::wc_reg_e offset,
                            output wordcopy_pkg::wc_word_t data);
        slave_address = offset;
        slave_read    = 1'b1;
        while (slave_waitrequest) @(negedge clk);
        @(negedge clk);  // data is valid in the cycle after the read completes
        data       = slave_readdata;
        slave_read = 1'b0;
    endtask

    // the same fill rule as the memory model, worked out on its own
    task automatic fill_shadow();
        for (int i = 0; i < 1024; i++) begin
            shadow[10'(i)] = wordcopy_pkg::wc_word_t'(i) * 32'd4 ^ 32'hA5A5_0000;
        end
    endtask

    // ascending word by word, so overlapping regions copy forward
    task automatic shadow_copy(input wordcopy_pkg::wc_word_t src,
                               input wordcopy_pkg::wc_word_t dst,
                               input wordcopy_pkg::wc_word_t cnt);
        wordcopy_pkg::wc_word_t s;
        wordcopy_pkg::wc_word_t d;
        s = src;
        d = dst;
        for (wordcopy_pkg::wc_word_t n = 0; n < cnt; n++) begin
            shadow[d[11:2]] = shadow[s[11:2]];
            s = s + wordcopy_pkg::WC_WORD_BYTES;
            d = d + wordcopy_pkg::WC_WORD_BYTES;
        end
    endtask

    task automatic run_job(input int t);
        string name;
        wordcopy_pkg::wc_word_t rd;
        name = test_name[t];
        mem0.preload();
        fill_shadow();
        bus_write(wordcopy_pkg::REG_DEST, test_dst[t]);
        bus_write(wordcopy_pkg::REG_SRC, test_src[t]);
        bus_write(wordcopy_pkg::REG_COUNT, test_cnt[t]);
        bus_write(wordcopy_pkg::REG_START_STATUS, '0);
        if (!slave_waitrequest) begin
            $display("%s: wait request was not raised after the start write", name);
            other_errors++;
        end
        // this start is issued during the job and has to wait for its end
        bus_write(wordcopy_pkg::REG_START_STATUS, '0);
        while (slave_waitrequest) @(negedge clk);
        shadow_copy(test_src[t], test_dst[t], test_cnt[t]);
        shadow_copy(test_src[t], test_dst[t], test_cnt[t]);  // the held second start
        for (int i = 0; i < 1024; i++) begin
            check_word($sformatf("%s word %0d", name, i), shadow[10'(i)], mem0.mem[10'(i)]);
        end
        bus_read(wordcopy_pkg::REG_START_STATUS, rd);
        check_count(name, test_cnt[t], rd);
        bus_read(wordcopy_pkg::REG_DEST, rd);
        check_word({name, " dest register"}, test_dst[t], rd);
        bus_read(wordcopy_pkg::REG_SRC, rd);
        check_word({name, " src register"}, test_src[t], rd);
        bus_read(wordcopy_pkg::REG_COUNT, rd);
        check_word({name, " count register"}, test_cnt[t], rd);
    endtask

    // watchdog, sized from the loaded jobs
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the jobs did not finish", cycle_limit);
            $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors + 1);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        slave_address   = wordcopy_pkg::REG_START_STATUS;
        slave_read      = 1'b0;
        slave_write     = 1'b0;
        slave_writedata = '0;
        load_tests();
        if (test_name.size() == 0) begin
            $display("no jobs were loaded from the test file");
            other_errors++;
        end
        foreach (test_cnt[t]) total_words += int'(test_cnt[t]);
        cycle_limit = 40 * total_words + 50 * test_name.size();
        wait (rst_n === 1'b1);
        @(negedge clk);
        foreach (test_name[t]) run_job(t);
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* test/wordcopy_tests.txt */
# columns: name, source byte address, destination byte address, word count
# addresses and counts are hex and stay inside the 4 KiB test memory
# each job is started twice, the second start being held until the first ends
single_low 000 800 1
single_top ffc 000 1
single_mid 4a8 b3c 1
single_adjacent 400 404 1
single_last 000 ffc 1
quad_a 100 900 4
quad_b a00 200 4
quad_top ff0 010 4
quad_d 0c4 e48 4
quad_repeat 100 900 4
block16_a 000 c00 10
block16_b c00 000 10
block16_c 5c0 240 10
block16_top fc0 880 10
zero_a 100 200 0
zero_top ffc 000 0
zero_overlap 200 204 0
zero_same 300 300 0
zero_after_big 000 400 0
overlap_up_1 700 704 1
overlap_up_3 060 064 3
overlap_up_4 300 304 4
overlap_up_16 600 604 10
overlap_up_gap2 900 908 8
overlap_up_32 a00 a04 20
overlap_up_half d00 d40 20
overlap_down_4 304 300 4
overlap_down_16 804 800 10
overlap_down_32 a04 a00 20
same_addr_4 500 500 4
copy_2 020 f00 2
copy_3 134 a70 3
copy_5 e00 0a0 5
copy_6 f00 000 6
copy_7 2c8 6f4 7
copy_8 b00 b40 8
copy_9 350 d90 9
copy_12 480 380 c
copy_15 1c0 7c0 f
copy_24 000 f00 18
copy_32 800 000 20
copy_32_back 000 800 20
copy_64 400 c00 40
tail_to_head f80 000 20
head_to_tail 000 f80 20
back_to_back_a 100 140 10
back_to_back_b 140 180 10
